// ==== vlog.f ====
+incdir+tests
design/u2_ctrl_pkg.sv
design/setting_decode.sv
design/setting_bank.sv
design/ctrl_outputs.sv
design/readback_mux.sv
design/u2_ctrl_top.sv
tests/u2_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: u2_ctrl

sources:
  - files:
      - design/u2_ctrl_pkg.sv
      - design/setting_decode.sv
      - design/setting_bank.sv
      - design/ctrl_outputs.sv
      - design/readback_mux.sv
      - design/u2_ctrl_top.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/u2_ctrl_tb.sv

// ==== tests/u2_ctrl_model.svh ====
////////////////////
// Reference model of the setting bank, board pins and readback
////////////////////

`ifndef U2_CTRL_MODEL_SVH
`define U2_CTRL_MODEL_SVH

// Stored settings plus the write that is one stage from the bank
u2_ctrl_pkg::setting_regs_t m_regs;
logic                       pend_we;
logic [7:0]                 pend_addr;
logic [31:0]                pend_data;
logic                       exp_flush;
logic                       exp_ack;
logic [31:0]                exp_rd_data;

function void model_reset();
   m_regs      = '0;
   pend_we     = 1'b0;
   pend_addr   = '0;
   pend_data   = '0;
   exp_flush   = 1'b0;
   exp_ack     = 1'b0;
   exp_rd_data = '0;
endfunction

// Unmapped addresses leave every field alone
function void store_setting(input logic [7:0] addr, input logic [31:0] data);
   case (addr)
      8'd0: m_regs.clk = data[4:0];
      8'd1: m_regs.ser = data[3:0];
      8'd2: m_regs.adc = data[3:0];
      8'd3: m_regs.led_sw = data[7:0];
      8'd4: m_regs.phy_reset = data[0];
      8'd6: m_regs.page = data[19:0];
      8'd8: m_regs.led_src = data[7:0];
      default: ;
   endcase
endfunction

function logic [31:0] readback_word(input logic [3:0] idx, input logic sim,
                                    input logic [3:0] div);
   logic [31:0] w;
   w = '0;
   case (idx)
      4'd0: w[4:0] = m_regs.clk;
      4'd1: w[3:0] = m_regs.ser;
      4'd2: w[3:0] = m_regs.adc;
      4'd3: w[7:0] = m_regs.led_sw;
      4'd4: w[0] = m_regs.phy_reset;
      4'd6: w[19:0] = m_regs.page;
      4'd8: w[7:0] = m_regs.led_src;
      4'd9: begin
         w[31]  = sim;
         w[3:0] = div;
      end
      default: ;
   endcase
   return w;
endfunction

function logic [7:0] exp_leds(input logic clk_stat, input logic link);
   logic [7:0] hw;
   hw = {6'b0, clk_stat, link};
   return (m_regs.led_src & hw) | (~m_regs.led_src & m_regs.led_sw);
endfunction

function logic [19:0] exp_ram_adr(input logic [15:0] local_word);
   logic [19:0] mask;
   mask = (20'd1 << PAGE_BITS) - 20'd1;
   return (m_regs.page & ~mask) | ({4'b0, local_word} & mask);
endfunction

// One rising edge, readback sees the settings from before the edge
function void model_clock(input u2_ctrl_pkg::set_bus_t bus, input u2_ctrl_pkg::rd_req_t req,
                          input logic sim, input logic [3:0] div);
   exp_ack = req.stb;
   if (req.stb) begin
      exp_rd_data = readback_word(req.addr, sim, div);
   end
   exp_flush = pend_we && (pend_addr == 8'd7);
   if (pend_we) begin
      store_setting(pend_addr, pend_data);
   end
   pend_we   = bus.stb;
   pend_addr = bus.addr;
   pend_data = bus.data;
endfunction

`endif

// ==== tests/u2_ctrl_tb.sv ====
////////////////////
// Control plane testbench
// Random settings traffic checked every cycle against a model
////////////////////

`timescale 1ns/10ps

module u2_ctrl_tb;

   localparam int PAGE_BITS  = 10;
   localparam int N_TRANS    = 560;
   // Four 100 ns cycles per transaction plus 20 us of margin
   localparam int TIMEOUT_NS = N_TRANS * 4 * 100 + 20000;

   logic                       dsp_clk;
   logic                       rst_n;
   u2_ctrl_pkg::set_bus_t      set_bus;
   u2_ctrl_pkg::rd_req_t       rd_req;
   logic                       clk_status;
   logic                       link_up;
   logic [15:0]                local_adr;
   logic                       sim_mode;
   logic [3:0]                 clock_divider;
   u2_ctrl_pkg::clk_ctrl_t     clk_ctrl;
   u2_ctrl_pkg::ser_ctrl_t     ser_ctrl;
   u2_ctrl_pkg::adc_ctrl_t     adc_ctrl;
   logic                       phy_reset_n;
   logic [7:0]                 leds;
   logic [19:0]                ram_adr;
   logic                       flush_icache;
   logic [31:0]                rd_data;
   logic                       rd_ack;

   int          checks;
   int          errors;
   bit          check_en;

   `include "u2_ctrl_model.svh"

   u2_ctrl_top #(
      .PAGE_BITS (PAGE_BITS)
   ) i_dut (
      .dsp_clk          (dsp_clk),
      .rst_n_i          (rst_n),
      .set_bus_i        (set_bus),
      .rd_req_i         (rd_req),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (link_up),
      .ram_local_adr_i  (local_adr),
      .sim_mode_i       (sim_mode),
      .clock_divider_i  (clock_divider),
      .clk_ctrl_o       (clk_ctrl),
      .ser_ctrl_o       (ser_ctrl),
      .adc_ctrl_o       (adc_ctrl),
      .phy_reset_n_o    (phy_reset_n),
      .leds_o           (leds),
      .ram_adr_o        (ram_adr),
      .flush_icache_o   (flush_icache),
      .rd_data_o        (rd_data),
      .rd_ack_o         (rd_ack)
   );

   initial dsp_clk = 1'b0;
   always #50 dsp_clk = ~dsp_clk;

   task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   ////////////////////
   // Model follows the rising edge, outputs are checked on the falling one
   always @(posedge dsp_clk) begin
      if (!rst_n) begin
         model_reset();
      end else begin
         model_clock(set_bus, rd_req, sim_mode, clock_divider);
      end
   end

   always @(negedge dsp_clk) begin
      if (check_en) begin
         compare("clk_ctrl_o", clk_ctrl, m_regs.clk);
         compare("ser_ctrl_o", ser_ctrl, m_regs.ser);
         compare("adc_ctrl_o", adc_ctrl, m_regs.adc);
         compare("phy_reset_n_o", phy_reset_n, !m_regs.phy_reset);
         compare("leds_o", leds, exp_leds(clk_status, link_up));
         compare("ram_adr_o", ram_adr, exp_ram_adr(local_adr));
         compare("flush_icache_o", flush_icache, exp_flush);
         compare("rd_ack_o", rd_ack, exp_ack);
         compare("rd_data_o", rd_data, exp_rd_data);
      end
   end

   ////////////////////
   // Stimulus
   // Strobes drop at every drive point unless set again
   task automatic next_cycle();
      @(posedge dsp_clk);
      #5;
      set_bus = '0;
      rd_req  = '0;
   endtask

   task automatic shake_status();
      clk_status = $urandom_range(1);
      link_up    = $urandom_range(1);
      local_adr  = $urandom_range(16'hffff);
   endtask

   // A gap of zero idle cycles gives back to back strobes
   task automatic idle_gap();
      repeat ($urandom_range(2)) begin
         next_cycle();
         shake_status();
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      next_cycle();
      shake_status();
      set_bus = '{stb: 1'b1, addr: addr, data: data};
      idle_gap();
   endtask

   task automatic read_setting(input logic [3:0] idx);
      next_cycle();
      shake_status();
      sim_mode      = $urandom_range(1);
      clock_divider = $urandom_range(15);
      rd_req        = '{stb: 1'b1, addr: idx};
      idle_gap();
   endtask

   task automatic report_test(input string name, input int c0, input int e0);
      $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish in the expected time");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      int c0;
      int e0;
      void'($urandom(3));
      rst_n         = 1'b0;
      set_bus       = '0;
      rd_req        = '0;
      clk_status    = 1'b0;
      link_up       = 1'b0;
      local_adr     = '0;
      sim_mode      = 1'b0;
      clock_divider = '0;
      checks        = 0;
      errors        = 0;
      check_en      = 1'b0;
      repeat (16) @(posedge dsp_clk);
      #5;
      rst_n    = 1'b1;
      check_en = 1'b1;

      // Reset state
      c0 = checks;
      e0 = errors;
      repeat (4) begin
         next_cycle();
         shake_status();
      end
      @(negedge dsp_clk);
      compare("reset clk_ctrl_o", clk_ctrl, 0);
      compare("reset ser_ctrl_o", ser_ctrl, 0);
      compare("reset adc_ctrl_o", adc_ctrl, 0);
      compare("reset phy_reset_n_o", phy_reset_n, 1);
      compare("reset leds_o", leds, 0);
      compare("reset flush_icache_o", flush_icache, 0);
      compare("reset rd_ack_o", rd_ack, 0);
      compare("reset ram_adr_o", ram_adr, local_adr & ((1 << PAGE_BITS) - 1));
      report_test("reset state", c0, e0);

      c0 = checks;
      e0 = errors;
      repeat (300) write_setting($urandom_range(15), $urandom);
      report_test("random writes", c0, e0);

      c0 = checks;
      e0 = errors;
      repeat (40) write_setting($urandom_range(1) ? 8'd7 : 8'($urandom_range(15)), $urandom);
      report_test("cache flush pulse", c0, e0);

      c0 = checks;
      e0 = errors;
      repeat (60) write_setting($urandom_range(1) ? 8'd3 : 8'd8, $urandom);
      report_test("led source mux", c0, e0);

      // Let the last write settle before reading back
      c0 = checks;
      e0 = errors;
      repeat (3) next_cycle();
      repeat (100) read_setting($urandom_range(15));
      repeat (2) next_cycle();
      report_test("readback", c0, e0);

      c0 = checks;
      e0 = errors;
      repeat (60) write_setting(8'd6, $urandom);
      repeat (3) next_cycle();
      report_test("paged ram address", c0, e0);

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== design/u2_ctrl_top.sv ====
////////////////////
// Radio core control plane
// Settings bus decode, register bank, board pins and readback
////////////////////

`timescale 1ns/10ps

module u2_ctrl_top #(
   parameter int PAGE_BITS = 10
) (
   input  logic                                dsp_clk,
   input  logic                                rst_n_i,

   // Settings bus and readback request
   input  u2_ctrl_pkg::set_bus_t               set_bus_i,
   input  u2_ctrl_pkg::rd_req_t                rd_req_i,

   // Status and local bus inputs
   input  logic                                clk_status_i,
   input  logic                                serdes_link_up_i,
   input  logic [u2_ctrl_pkg::LOC_ADR_W-1:0]   ram_local_adr_i,
   input  logic                                sim_mode_i,
   input  logic [3:0]                          clock_divider_i,

   // Board pins
   output u2_ctrl_pkg::clk_ctrl_t              clk_ctrl_o,
   output u2_ctrl_pkg::ser_ctrl_t              ser_ctrl_o,
   output u2_ctrl_pkg::adc_ctrl_t              adc_ctrl_o,
   output logic                                phy_reset_n_o,
   output logic [u2_ctrl_pkg::LED_W-1:0]       leds_o,
   output logic [u2_ctrl_pkg::RAM_ADDR_W-1:0]  ram_adr_o,

   // Cache flush and readback
   output logic                                flush_icache_o,
   output logic [u2_ctrl_pkg::SET_DATA_W-1:0]  rd_data_o,
   output logic                                rd_ack_o
);

   u2_ctrl_pkg::setting_wr_t   wr;
   u2_ctrl_pkg::setting_regs_t regs;

   ////////////////////
   // Write path, strobe to pins in two edges
   setting_decode i_setting_decode (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .set_bus_i (set_bus_i),
      .wr_o      (wr)
   );

   setting_bank i_setting_bank (
      .dsp_clk        (dsp_clk),
      .rst_n_i        (rst_n_i),
      .wr_i           (wr),
      .regs_o         (regs),
      .flush_icache_o (flush_icache_o)
   );

   ctrl_outputs #(
      .PAGE_BITS (PAGE_BITS)
   ) i_ctrl_outputs (
      .regs_i           (regs),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .ram_local_adr_i  (ram_local_adr_i),
      .clk_ctrl_o       (clk_ctrl_o),
      .ser_ctrl_o       (ser_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .leds_o           (leds_o),
      .ram_adr_o        (ram_adr_o)
   );

   ////////////////////
   // Readback path
   readback_mux i_readback_mux (
      .dsp_clk         (dsp_clk),
      .rst_n_i         (rst_n_i),
      .rd_req_i        (rd_req_i),
      .regs_i          (regs),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .rd_data_o       (rd_data_o),
      .rd_ack_o        (rd_ack_o)
   );

endmodule

// ==== design/readback_mux.sv ====
////////////////////
// Settings readback
// Registered word select with a one cycle acknowledge
////////////////////

`timescale 1ns/10ps

module readback_mux (
   input  logic                                dsp_clk,
   input  logic                                rst_n_i,
   input  u2_ctrl_pkg::rd_req_t                rd_req_i,
   input  u2_ctrl_pkg::setting_regs_t          regs_i,
   input  logic                                sim_mode_i,
   input  logic [3:0]                          clock_divider_i,
   output logic [u2_ctrl_pkg::SET_DATA_W-1:0]  rd_data_o,
   output logic                                rd_ack_o
);

   localparam int DATA_W = u2_ctrl_pkg::SET_DATA_W;

   logic [DATA_W-1:0] word;
   logic [DATA_W-1:0] data_q;
   logic              ack_q;

   // Word map, indices 0..8 follow the settings addresses
   always_comb begin
      word = '0;
      case (rd_req_i.addr)
         4'd0: word[$bits(regs_i.clk)-1:0]     = regs_i.clk;
         4'd1: word[$bits(regs_i.ser)-1:0]     = regs_i.ser;
         4'd2: word[$bits(regs_i.adc)-1:0]     = regs_i.adc;
         4'd3: word[$bits(regs_i.led_sw)-1:0]  = regs_i.led_sw;
         4'd4: word[0]                         = regs_i.phy_reset;
         4'd6: word[$bits(regs_i.page)-1:0]    = regs_i.page;
         4'd8: word[$bits(regs_i.led_src)-1:0] = regs_i.led_src;
         // Mode word
         4'd9: word = {sim_mode_i, {(DATA_W-5){1'b0}}, clock_divider_i};
         default: word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         ack_q  <= 1'b0;
         data_q <= '0;
      end else begin
         ack_q <= rd_req_i.stb;
         // Data holds between requests
         if (rd_req_i.stb) begin
            data_q <= word;
         end
      end
   end

   assign rd_ack_o  = ack_q;
   assign rd_data_o = data_q;

endmodule

// ==== design/ctrl_outputs.sv ====
////////////////////
// Board control pins
// Drives pins, LED mux and paged RAM address from the settings
////////////////////

`timescale 1ns/10ps

module ctrl_outputs #(
   parameter int PAGE_BITS = 10
) (
   input  u2_ctrl_pkg::setting_regs_t             regs_i,
   input  logic                                   clk_status_i,
   input  logic                                   serdes_link_up_i,
   input  logic [u2_ctrl_pkg::LOC_ADR_W-1:0]      ram_local_adr_i,
   output u2_ctrl_pkg::clk_ctrl_t                 clk_ctrl_o,
   output u2_ctrl_pkg::ser_ctrl_t                 ser_ctrl_o,
   output u2_ctrl_pkg::adc_ctrl_t                 adc_ctrl_o,
   output logic                                   phy_reset_n_o,
   output logic [u2_ctrl_pkg::LED_W-1:0]          leds_o,
   output logic [u2_ctrl_pkg::RAM_ADDR_W-1:0]     ram_adr_o
);

   localparam int RAM_W = u2_ctrl_pkg::RAM_ADDR_W;
   localparam int LED_W = u2_ctrl_pkg::LED_W;

   logic [LED_W-1:0] led_hw;

   ////////////////////
   // Direct pin groups
   assign clk_ctrl_o = regs_i.clk;
   assign ser_ctrl_o = regs_i.ser;
   assign adc_ctrl_o = regs_i.adc;

   // Stored bit is the reset request, pin is active low
   assign phy_reset_n_o = ~regs_i.phy_reset;

   ////////////////////
   // LEDs
   // Hardware status word, clock status above link up
   assign led_hw = {{(LED_W-2){1'b0}}, clk_status_i, serdes_link_up_i};

   // Per bit choice, 1 = hardware, 0 = software
   always_comb begin
      for (int i = 0; i < LED_W; i++) begin
         leds_o[i] = regs_i.led_src[i] ? led_hw[i] : regs_i.led_sw[i];
      end
   end

   ////////////////////
   // External RAM address
   // Page register supplies the upper bits, local bus the offset
   assign ram_adr_o = {regs_i.page[RAM_W-1:PAGE_BITS], ram_local_adr_i[PAGE_BITS-1:0]};

endmodule

// ==== design/setting_bank.sv ====
////////////////////
// Setting register bank
// Stores decoded writes and pulses the cache flush
////////////////////

`timescale 1ns/10ps

module setting_bank (
   input  logic                       dsp_clk,
   input  logic                       rst_n_i,
   input  u2_ctrl_pkg::setting_wr_t   wr_i,
   output u2_ctrl_pkg::setting_regs_t regs_o,
   output logic                       flush_icache_o
);

   u2_ctrl_pkg::setting_regs_t regs_q;
   logic                       flush_q;

   ////////////////////
   // Register writes
   // Each field takes the low bits of the data word
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         regs_q <= '0;
      end else if (wr_i.we) begin
         case (wr_i.sel)
            u2_ctrl_pkg::SR_CLK: begin
               regs_q.clk <= wr_i.data[$bits(regs_q.clk)-1:0];
            end
            u2_ctrl_pkg::SR_SER: begin
               regs_q.ser <= wr_i.data[$bits(regs_q.ser)-1:0];
            end
            u2_ctrl_pkg::SR_ADC: begin
               regs_q.adc <= wr_i.data[$bits(regs_q.adc)-1:0];
            end
            u2_ctrl_pkg::SR_LED: begin
               regs_q.led_sw <= wr_i.data[$bits(regs_q.led_sw)-1:0];
            end
            u2_ctrl_pkg::SR_PHY: begin
               regs_q.phy_reset <= wr_i.data[0];
            end
            u2_ctrl_pkg::SR_PAGE: begin
               regs_q.page <= wr_i.data[$bits(regs_q.page)-1:0];
            end
            u2_ctrl_pkg::SR_LED_SRC: begin
               regs_q.led_src <= wr_i.data[$bits(regs_q.led_src)-1:0];
            end
            // SR_ICACHE keeps nothing, it only fires the flush
            default: begin
               regs_q <= regs_q;
            end
         endcase
      end
   end

   ////////////////////
   // Cache flush
   // One cycle high per SR_ICACHE write, back to back writes give
   // back to back pulses
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         flush_q <= 1'b0;
      end else begin
         flush_q <= wr_i.we && (wr_i.sel == u2_ctrl_pkg::SR_ICACHE);
      end
   end

   assign regs_o         = regs_q;
   assign flush_icache_o = flush_q;

endmodule

// ==== design/setting_decode.sv ====
////////////////////
// Settings write decode
// Registers the strobe and matches the address to the map
////////////////////

`timescale 1ns/10ps

module setting_decode (
   input  logic                     dsp_clk,
   input  logic                     rst_n_i,
   input  u2_ctrl_pkg::set_bus_t    set_bus_i,
   output u2_ctrl_pkg::setting_wr_t wr_o
);

   logic                                mapped;
   u2_ctrl_pkg::setting_addr_e          sel_d;
   logic                                we_q;
   u2_ctrl_pkg::setting_addr_e          sel_q;
   logic [u2_ctrl_pkg::SET_DATA_W-1:0]  data_q;

   // Address match, unmapped addresses fall through to default
   always_comb begin
      mapped = 1'b1;
      sel_d  = u2_ctrl_pkg::SR_CLK;
      case (set_bus_i.addr)
         u2_ctrl_pkg::SR_CLK:     sel_d = u2_ctrl_pkg::SR_CLK;
         u2_ctrl_pkg::SR_SER:     sel_d = u2_ctrl_pkg::SR_SER;
         u2_ctrl_pkg::SR_ADC:     sel_d = u2_ctrl_pkg::SR_ADC;
         u2_ctrl_pkg::SR_LED:     sel_d = u2_ctrl_pkg::SR_LED;
         u2_ctrl_pkg::SR_PHY:     sel_d = u2_ctrl_pkg::SR_PHY;
         u2_ctrl_pkg::SR_PAGE:    sel_d = u2_ctrl_pkg::SR_PAGE;
         u2_ctrl_pkg::SR_ICACHE:  sel_d = u2_ctrl_pkg::SR_ICACHE;
         u2_ctrl_pkg::SR_LED_SRC: sel_d = u2_ctrl_pkg::SR_LED_SRC;
         default:                 mapped = 1'b0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         we_q <= 1'b0;
      end else begin
         we_q <= set_bus_i.stb & mapped;
      end
   end

   // Select and data only matter while we_q is high
   always_ff @(posedge dsp_clk) begin
      sel_q  <= sel_d;
      data_q <= set_bus_i.data;
   end

   assign wr_o = '{we: we_q, sel: sel_q, data: data_q};

endmodule

// ==== design/u2_ctrl_pkg.sv ====
////////////////////
// Radio core control plane shared types
// Settings bus, register map, pin groups and readback request
////////////////////

package u2_ctrl_pkg;

   ////////////////////
   // Widths
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_ADDR_W  = 4;
   localparam int RAM_ADDR_W = 20;
   localparam int LED_W      = 8;
   localparam int LOC_ADR_W  = 16;

   ////////////////////
   // Register map
   // Address 5 and 9 and up are not decoded
   typedef enum logic [SET_ADDR_W-1:0] {
      SR_CLK     = 8'd0,
      SR_SER     = 8'd1,
      SR_ADC     = 8'd2,
      SR_LED     = 8'd3,
      SR_PHY     = 8'd4,
      SR_PAGE    = 8'd6,
      SR_ICACHE  = 8'd7,
      SR_LED_SRC = 8'd8
   } setting_addr_e;

   // Raw write as it arrives on the settings bus
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   // Write after address decode
   typedef struct packed {
      logic                  we;
      setting_addr_e         sel;
      logic [SET_DATA_W-1:0] data;
   } setting_wr_t;

   ////////////////////
   // Board pin groups, MSB first as packed in the data word
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clk_ctrl_t;

   typedef struct packed {
      logic ser_enable;
      logic ser_prbsen;
      logic ser_loopen;
      logic ser_rx_en;
   } ser_ctrl_t;

   typedef struct packed {
      logic adc_oe_a;
      logic adc_on_a;
      logic adc_oe_b;
      logic adc_on_b;
   } adc_ctrl_t;

   // Everything the bank holds
   typedef struct packed {
      clk_ctrl_t             clk;
      ser_ctrl_t             ser;
      adc_ctrl_t             adc;
      logic [LED_W-1:0]      led_sw;
      logic                  phy_reset;
      logic [RAM_ADDR_W-1:0] page;
      logic [LED_W-1:0]      led_src;
   } setting_regs_t;

   typedef struct packed {
      logic                 stb;
      logic [RB_ADDR_W-1:0] addr;
   } rd_req_t;

endpackage
